//--- dv/frontEnd_stimulus.txt
// All values hex. Header: instructions to check, then the number of memory lines.
// Memory line: address, word, bus-error flag, class (0 rType .. 6 reserved), expected decImm.
00000028 00000017
00000000 2008fffc 0 1 fffffffc
00000004 25091234 0 1 00001234
00000008 292a8000 0 1 ffff8000
0000000c 2d4b0007 0 1 00000007
00000010 316cf0f0 0 2 0000f0f0
00000014 358d8001 0 2 00008001
00000018 39aeffff 0 2 0000ffff
0000001c 3c0fabcd 0 2 abcd0000
00000020 00221820 0 0 00000000
00000024 8fa4fff8 0 3 fffffff8
00000028 afa50010 0 3 00000010
0000002c 1022fffd 0 4 fffffffd
00000030 14640005 0 4 00000005
00000034 fc211234 0 6 00000000
00000038 0c000014 0 5 00000000
0000003c 20010001 0 1 00000001
00000040 24420001 0 1 00000001
00000044 08000014 0 5 00000000
00000048 3c011111 0 2 11110000
00000050 34c60100 0 2 00000100
00000054 08000000 1 5 00000000
00000058 08000010 0 5 00000000
0000005c 20030003 0 1 00000003

//--- frontEnd.f
verilog/frontPkg.sv
verilog/frontIfs.sv
verilog/pcGen.sv
verilog/branchTargetBuffer.sv
verilog/idReg.sv
verilog/instrDecode.sv
verilog/frontEnd.sv
dv/frontEnd_asserts.sv
dv/frontEndTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the front-end testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module frontEndTb -f frontEnd.f -o frontEndSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/frontEndSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi

exit 0

//--- dv/frontEndTb.sv
// Testbench for the front end: clock, reset, file-driven memory model, reference PC walk and checks.

`timescale 1ns/1ns

module frontEndTb import frontPkg::*; ();

    logic        clk;
    logic        arstN;
    logic        stall;
    logic [31:0] imemData;
    logic        imemErr;
    logic [31:0] imemAddr;
    logic        decValid;
    logic [31:0] decPc;
    logic [31:0] decInstr;
    logic [4:0]  decRs;
    logic [4:0]  decRt;
    logic [4:0]  decRd;
    logic [31:0] decImm;
    instrClassE  decClass;
    exceptT      decExcept;

    // raw words of the stimulus file and the program image built from them.
    // the image covers the first 1 KiB of the address space, one slot per word.
    logic [31:0] stimWords [0:255];
    logic [31:0] progWord  [0:255];
    logic        progErr   [0:255];
    instrClassE  progClass [0:255];
    logic [31:0] progImm   [0:255];

    int          runLength;
    int          timeoutLimit;
    int          cycleCount;
    int          checkedCount;
    logic [31:0] refPc;

    frontEnd dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // the instruction memory answers in the same cycle, unlisted words read as zero.
    always_comb begin
        if (imemAddr < 32'd1024) begin
            imemData = progWord[imemAddr[9:2]];
            imemErr  = progErr[imemAddr[9:2]];
        end else begin
            imemData = '0;
            imemErr  = 1'b0;
        end
    end

    // --------------------------------------------------
    // failure reporting and compare tasks
    // --------------------------------------------------
    task automatic abortRun();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic reportMismatch(input string what);
        $display("MISMATCH at %0t ns, PC 0x%08h: %s", $time, refPc, what);
        abortRun();
    endtask

    task automatic checkPc(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            reportMismatch($sformatf("decPc is 0x%08h, expected 0x%08h", got, exp));
        end
    endtask

    task automatic checkInstr(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            reportMismatch($sformatf("decInstr is 0x%08h, expected 0x%08h", got, exp));
        end
    endtask

    task automatic checkFields(input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
                               input logic [4:0] expRs, input logic [4:0] expRt,
                               input logic [4:0] expRd);
        if (rs !== expRs || rt !== expRt || rd !== expRd) begin
            reportMismatch($sformatf("rs/rt/rd are %0d/%0d/%0d, expected %0d/%0d/%0d",
                                     rs, rt, rd, expRs, expRt, expRd));
        end
    endtask

    task automatic checkClass(input instrClassE got, input instrClassE exp);
        if (got !== exp) begin
            reportMismatch($sformatf("decClass is %s, expected %s", got.name(), exp.name()));
        end
    endtask

    task automatic checkImm(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            reportMismatch($sformatf("decImm is 0x%08h, expected 0x%08h", got, exp));
        end
    endtask

    task automatic checkExcept(input exceptT got, input exceptT exp);
        if (got !== exp) begin
            reportMismatch($sformatf("busErr/reserved are %b/%b, expected %b/%b",
                                     got.instrBusErr, got.reservedInstr,
                                     exp.instrBusErr, exp.reservedInstr));
        end
    endtask

    // --------------------------------------------------
    // stimulus file and reference model
    // --------------------------------------------------
    task automatic loadStimulus();
        int          numEntries;
        int          base;
        logic [31:0] addr;
        for (int i = 0; i < 256; i++) begin
            progWord[i]  = '0;
            progErr[i]   = 1'b0;
            progClass[i] = rType;
            progImm[i]   = '0;
        end
        $readmemh("dv/frontEnd_stimulus.txt", stimWords);
        runLength  = int'(stimWords[0]);
        numEntries = int'(stimWords[1]);
        if (runLength == 0 || numEntries == 0 || 2 + 5 * numEntries > 256) begin
            $display("ERROR: the stimulus file is missing or its header is out of range");
            abortRun();
        end
        for (int i = 0; i < numEntries; i++) begin
            base = 2 + 5 * i;
            addr = stimWords[base];
            if (addr >= 32'd1024 || addr[1:0] != 2'b00) begin
                $display("ERROR: stimulus address 0x%08h is outside the modelled memory", addr);
                abortRun();
            end
            progWord[addr[9:2]]  = stimWords[base + 1];
            progErr[addr[9:2]]   = stimWords[base + 2][0];
            progClass[addr[9:2]] = instrClassE'(stimWords[base + 3][2:0]);
            progImm[addr[9:2]]   = stimWords[base + 4];
        end
        // twenty cycles per instruction leaves room for stalls and redirects.
        timeoutLimit = 20 * runLength + 200;
    endtask

    // architectural successor: J and JAL are taken unless the fetch failed.
    function automatic logic [31:0] nextPcOf(input logic [31:0] pc, input logic [31:0] word,
                                             input logic busErr);
        logic [31:0] seqPc;
        seqPc = pc + 32'd4;
        if (!busErr && (word[31:26] == OP_J || word[31:26] == OP_JAL)) begin
            return {seqPc[31:28], word[25:0], 2'b00};
        end
        return seqPc;
    endfunction

    // --------------------------------------------------
    // reset, stall driver and checks
    // --------------------------------------------------
    initial begin
        arstN        = 1'b0;
        stall        = 1'b0;
        cycleCount   = 0;
        checkedCount = 0;
        refPc        = RESET_VECTOR;
        void'($urandom(32'hac5c));
        loadStimulus();
        repeat (16) @(posedge clk);
        #1;
        arstN = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            // roughly one cycle in four is stalled.
            stall = ($urandom % 4) == 32'd0;
        end
    end

    // outputs are settled half a cycle after the edge that produced them.
    always @(negedge clk) begin
        logic [7:0]  slot;
        logic [31:0] expWord;
        exceptT      expExcept;
        if (arstN && !stall && decValid) begin
            if (refPc >= 32'd1024) begin
                $display("ERROR: reference PC 0x%08h left the program image", refPc);
                abortRun();
            end
            slot      = refPc[9:2];
            expWord   = progWord[slot];
            expExcept = '{instrBusErr:   progErr[slot],
                          reservedInstr: (progClass[slot] == reserved)};
            checkPc(decPc, refPc);
            checkInstr(decInstr, expWord);
            checkFields(decRs, decRt, decRd, expWord[25:21], expWord[20:16], expWord[15:11]);
            checkClass(decClass, progClass[slot]);
            checkImm(decImm, progImm[slot]);
            checkExcept(decExcept, expExcept);
            refPc = nextPcOf(refPc, expWord, progErr[slot]);
            checkedCount++;
            if (checkedCount == runLength) begin
                $display("Simulation PASSED");
                $finish;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutLimit) begin
            $display("ERROR: run did not finish, %0d of %0d instructions checked in %0d cycles",
                     checkedCount, runLength, timeoutLimit);
            abortRun();
        end
    end

endmodule

//--- dv/frontEnd_asserts.sv
// Assertions bound to the front-end top level: reset, stall hold, redirect flush, fetch alignment.

`timescale 1ns/1ns

module frontEndAsserts import frontPkg::*; (
    input logic        clk,
    input logic        arstN,
    input logic        stall,
    input logic        redirect,
    input logic [31:0] imemAddr,
    input logic        decValid,
    input logic [31:0] decPc,
    input logic [31:0] decInstr,
    input logic [4:0]  decRs,
    input logic [4:0]  decRt,
    input logic [4:0]  decRd,
    input logic [31:0] decImm,
    input instrClassE  decClass,
    input exceptT      decExcept
);

    noValidInReset: assert property (@(posedge clk) !arstN |-> !decValid)
        else $error("decValid is high while reset is asserted");

    // a stalled edge must leave every decode output unchanged.
    holdWhileStalled: assert property (@(posedge clk) disable iff (!arstN)
        stall |=> ($stable(decValid) && $stable(decPc) && $stable(decInstr) &&
                   $stable(decRs) && $stable(decRt) && $stable(decRd) &&
                   $stable(decImm) && $stable(decClass) && $stable(decExcept)))
        else $error("decode outputs changed across a stalled cycle");

    // redirect only fires unstalled, so the flush lands in the very next cycle.
    flushAfterRedirect: assert property (@(posedge clk) disable iff (!arstN)
        redirect |=> !decValid)
        else $error("decValid is high right after a redirect");

    wordAligned: assert property (@(posedge clk) imemAddr[1:0] == 2'b00)
        else $error("imemAddr is not word aligned");

endmodule

bind frontEnd frontEndAsserts uAsserts (.*);

//--- verilog/frontEnd.sv
// Top level of the instruction front end: PC generator, BTB, IF/ID register and decoder.

`timescale 1ns/1ns

module frontEnd import frontPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        stall,
    input  logic [31:0] imemData,
    input  logic        imemErr,
    output logic [31:0] imemAddr,
    output logic        decValid,
    output logic [31:0] decPc,
    output logic [31:0] decInstr,
    output logic [4:0]  decRs,
    output logic [4:0]  decRt,
    output logic [4:0]  decRd,
    output logic [31:0] decImm,
    output instrClassE  decClass,
    output exceptT      decExcept
);

    fetchIf     fetchBus ();
    btbUpdateIf btbUpd ();

    predT        pred;
    logic        redirect;
    logic [31:0] redirectPc;
    logic [15:0] idImm16;
    exceptT      idExcept;
    predT        idPred;

    // --------------------------------------------------
    // fetch stage
    // --------------------------------------------------
    pcGen uPcGen (
        .clk        (clk),
        .arstN      (arstN),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .pred       (pred),
        .imemData   (imemData),
        .imemErr    (imemErr),
        .fetch      (fetchBus.driver),
        .pc         (imemAddr)
    );

    branchTargetBuffer uBtb (
        .clk      (clk),
        .arstN    (arstN),
        .lookupPc (imemAddr),
        .pred     (pred),
        .upd      (btbUpd.sink)
    );

    // --------------------------------------------------
    // decode stage
    // --------------------------------------------------
    // the redirect from decode doubles as the IF/ID flush.
    idReg uIdReg (
        .clk      (clk),
        .arstN    (arstN),
        .flush    (redirect),
        .stall    (stall),
        .fetch    (fetchBus.sink),
        .idInstr  (decInstr),
        .idPc     (decPc),
        .idRs     (decRs),
        .idRt     (decRt),
        .idRd     (decRd),
        .idImm16  (idImm16),
        .idExcept (idExcept),
        .idPred   (idPred),
        .idValid  (decValid)
    );

    instrDecode uDecode (
        .stall      (stall),
        .idInstr    (decInstr),
        .idPc       (decPc),
        .idImm16    (idImm16),
        .idExcept   (idExcept),
        .idPred     (idPred),
        .idValid    (decValid),
        .decClass   (decClass),
        .decImm     (decImm),
        .decExcept  (decExcept),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .upd        (btbUpd.driver)
    );

endmodule

//--- verilog/instrDecode.sv
// Instruction decoder: class, immediate extension, reserved-opcode detection and jump resolution.

`timescale 1ns/1ns

module instrDecode import frontPkg::*; (
    input  logic        stall,
    input  logic [31:0] idInstr,
    input  logic [31:0] idPc,
    input  logic [15:0] idImm16,
    input  exceptT      idExcept,
    input  predT        idPred,
    input  logic        idValid,
    output instrClassE  decClass,
    output logic [31:0] decImm,
    output exceptT      decExcept,
    output logic        redirect,
    output logic [31:0] redirectPc,
    btbUpdateIf.driver  upd
);

    logic [5:0]  opcode;
    logic [31:0] pcPlus4;
    logic [31:0] jumpTarget;
    logic        isJump;
    logic        jumpMiss;
    logic        falseTaken;
    logic        canResolve;

    assign opcode = idInstr[31:26];

    // --------------------------------------------------
    // classification
    // --------------------------------------------------
    always_comb begin
        case (opcode)
            OP_SPECIAL:                           decClass = rType;
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: decClass = immArith;
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI:     decClass = immLogic;
            OP_LW, OP_SW:                         decClass = memory;
            OP_BEQ, OP_BNE:                       decClass = branch;
            OP_J, OP_JAL:                         decClass = jump;
            default:                              decClass = reserved;
        endcase
    end

    // arithmetic, load/store offsets and branch offsets are signed, logic immediates are not.
    always_comb begin
        case (decClass)
            immArith, memory, branch: decImm = {{16{idImm16[15]}}, idImm16};
            immLogic: begin
                if (opcode == OP_LUI) begin
                    decImm = {idImm16, 16'h0000};
                end else begin
                    decImm = {16'h0000, idImm16};
                end
            end
            default: decImm = '0;
        endcase
    end

    assign decExcept = '{instrBusErr:   idExcept.instrBusErr,
                         reservedInstr: idExcept.reservedInstr || (decClass == reserved)};

    // --------------------------------------------------
    // jump resolution
    // --------------------------------------------------
    assign pcPlus4    = idPc + 32'd4;
    assign jumpTarget = {pcPlus4[31:28], idInstr[25:0], 2'b00};
    assign isJump     = (decClass == jump);
    assign canResolve = idValid && !stall && !idExcept.instrBusErr;

    // a jump must have been predicted taken to the exact target.
    assign jumpMiss   = isJump && (!idPred.predTaken || (idPred.predTarget != jumpTarget));
    // anything else must not have been predicted taken at all.
    assign falseTaken = !isJump && idPred.predTaken;

    assign redirect   = canResolve && (jumpMiss || falseTaken);
    assign redirectPc = isJump ? jumpTarget : pcPlus4;

    // the correction goes into the BTB in the same cycle as the redirect.
    assign upd.wrEn     = redirect;
    assign upd.wrPc     = idPc;
    assign upd.wrTarget = redirectPc;
    assign upd.wrTaken  = isJump;

endmodule

//--- verilog/idReg.sv
// IF/ID pipeline register with stall hold, flush and register field extraction.

`timescale 1ns/1ns

module idReg import frontPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        flush,
    input  logic        stall,
    fetchIf.sink        fetch,
    output logic [31:0] idInstr,
    output logic [31:0] idPc,
    output logic [4:0]  idRs,
    output logic [4:0]  idRt,
    output logic [4:0]  idRd,
    output logic [15:0] idImm16,
    output exceptT      idExcept,
    output predT        idPred,
    output logic        idValid
);

    // a flush turns the slot into a bubble, which decodes as an invalid zero word.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idInstr  <= '0;
            idPc     <= '0;
            idRs     <= '0;
            idRt     <= '0;
            idRd     <= '0;
            idImm16  <= '0;
            idExcept <= '0;
            idPred   <= '0;
            idValid  <= 1'b0;
        end else if (flush) begin
            idInstr  <= '0;
            idPc     <= '0;
            idRs     <= '0;
            idRt     <= '0;
            idRd     <= '0;
            idImm16  <= '0;
            idExcept <= '0;
            idPred   <= '0;
            idValid  <= 1'b0;
        end else if (!stall) begin
            idInstr  <= fetch.instr;
            idPc     <= fetch.pc;
            idRs     <= fetch.instr[25:21];
            idRt     <= fetch.instr[20:16];
            idRd     <= fetch.instr[15:11];
            idImm16  <= fetch.instr[15:0];
            idExcept <= fetch.except;
            idPred   <= fetch.pred;
            idValid  <= 1'b1;
        end
    end

endmodule

//--- verilog/branchTargetBuffer.sv
// Direct-mapped jump target buffer with a combinational lookup and one write port.

`timescale 1ns/1ns

module branchTargetBuffer import frontPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic [31:0] lookupPc,
    output predT        pred,
    btbUpdateIf.sink    upd
);

    logic [BTB_ENTRIES-1:0] entryValid;
    logic [BTB_TAG_W-1:0]   entryTag    [BTB_ENTRIES];
    logic [31:0]            entryTarget [BTB_ENTRIES];
    logic                   entryTaken  [BTB_ENTRIES];

    logic [BTB_INDEX_W-1:0] lookupIdx;
    logic [BTB_TAG_W-1:0]   lookupTag;
    logic [BTB_INDEX_W-1:0] wrIdx;
    logic [BTB_TAG_W-1:0]   wrTag;
    logic                   hit;

    // entries are indexed by word address, the byte offset is ignored.
    assign lookupIdx = lookupPc[BTB_INDEX_W+1:2];
    assign lookupTag = lookupPc[31:BTB_INDEX_W+2];
    assign wrIdx     = upd.wrPc[BTB_INDEX_W+1:2];
    assign wrTag     = upd.wrPc[31:BTB_INDEX_W+2];

    // --------------------------------------------------
    // lookup
    // --------------------------------------------------
    assign hit = entryValid[lookupIdx] && (entryTag[lookupIdx] == lookupTag);

    assign pred.predTaken  = hit && entryTaken[lookupIdx];
    assign pred.predTarget = entryTarget[lookupIdx];

    // --------------------------------------------------
    // update
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entryValid <= '0;
        end else if (upd.wrEn) begin
            entryValid[wrIdx] <= 1'b1;
        end
    end

    // a write always replaces the whole entry, a cleared taken bit included.
    always_ff @(posedge clk) begin
        if (upd.wrEn) begin
            entryTag[wrIdx]    <= wrTag;
            entryTarget[wrIdx] <= upd.wrTarget;
            entryTaken[wrIdx]  <= upd.wrTaken;
        end
    end

endmodule

//--- verilog/pcGen.sv
// PC generator: program counter register, next-PC selection and packing of the fetch bundle.

`timescale 1ns/1ns

module pcGen import frontPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] redirectPc,
    input  predT        pred,
    input  logic [31:0] imemData,
    input  logic        imemErr,
    fetchIf.driver      fetch,
    output logic [31:0] pc
);

    logic [31:0] pcReg;
    logic [31:0] nextPc;
    logic        takePred;

    // a word that came back with a bus error is never followed as a jump,
    // so its lookup result is dropped here as well.
    assign takePred = pred.predTaken && !imemErr;

    // --------------------------------------------------
    // next PC
    // --------------------------------------------------
    always_comb begin
        if (redirect) begin
            nextPc = redirectPc;
        end else if (takePred) begin
            nextPc = pred.predTarget;
        end else begin
            nextPc = pcReg + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcReg <= RESET_VECTOR;
        end else if (!stall) begin
            pcReg <= nextPc;
        end
    end

    assign pc = pcReg;

    // the memory answers in the same cycle, so the bundle is built straight from the port.
    assign fetch.pc     = pcReg;
    assign fetch.instr  = imemData;
    assign fetch.except = '{instrBusErr: imemErr, reservedInstr: 1'b0};
    assign fetch.pred   = '{predTaken: takePred, predTarget: pred.predTarget};

endmodule

//--- verilog/frontIfs.sv
// Interfaces of the front end: the fetch bundle into IF/ID and the BTB write port from decode.

`timescale 1ns/1ns

// --------------------------------------------------
// fetch bundle, one instruction per unstalled cycle
// --------------------------------------------------
interface fetchIf import frontPkg::*; ();

    logic [31:0] pc;
    logic [31:0] instr;
    exceptT      except;
    predT        pred;

    // fetch side.
    modport driver (
        output pc,
        output instr,
        output except,
        output pred
    );

    // IF/ID register side.
    modport sink (
        input pc,
        input instr,
        input except,
        input pred
    );

endinterface

// --------------------------------------------------
// BTB correction written by decode
// --------------------------------------------------
interface btbUpdateIf ();

    logic        wrEn;
    logic [31:0] wrPc;
    logic [31:0] wrTarget;
    logic        wrTaken;

    modport driver (output wrEn, output wrPc, output wrTarget, output wrTaken);
    modport sink (input wrEn, input wrPc, input wrTarget, input wrTaken);

endinterface

//--- verilog/frontPkg.sv
// Instruction class, exception and prediction structs, BTB sizes and opcode values.

package frontPkg;

    // --------------------------------------------------
    // decoded instruction class
    // --------------------------------------------------
    typedef enum logic [2:0] {
        rType,
        immArith,
        immLogic,
        memory,
        branch,
        jump,
        reserved
    } instrClassE;

    // exception flags that travel down the pipeline with an instruction.
    typedef struct packed {
        logic instrBusErr;
        logic reservedInstr;
    } exceptT;

    // prediction made at fetch time, checked again in decode.
    typedef struct packed {
        logic        predTaken;
        logic [31:0] predTarget;
    } predT;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------
    localparam logic [31:0] RESET_VECTOR = 32'h0000_0000;
    localparam int          BTB_ENTRIES  = 16;
    localparam int          BTB_INDEX_W  = 4;
    // the tag is the part of the PC above the index and the two byte-offset bits.
    localparam int          BTB_TAG_W    = 32 - BTB_INDEX_W - 2;

    // --------------------------------------------------
    // primary opcodes, instruction bits 31:26
    // --------------------------------------------------
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

endpackage
